// ==== hdl/dispatch_defines.svh ====
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// memory bus widths
`define DISPATCH_ADDR_W 32
`define DISPATCH_DATA_W 32

// processors hanging off the dispatcher
`define DISPATCH_CPU_QUANTITY 4

// index bus toward the processors
`define DISPATCH_CPU_INDEX_W 8

// flag or'ed into the index of an active processor grant
`define DISPATCH_CPU_ACTIVE 8'h80

// slot handed to a processor that has not started yet
`define DISPATCH_CPU_NONACTIVE 8'h40

`endif

// ==== hdl/dispatch_types_pkg.sv ====
`include "dispatch_defines.svh"

package dispatch_types_pkg;

  // byte address on the external memory bus
  typedef logic [`DISPATCH_ADDR_W-1:0] addr_t;

  // one memory word
  typedef logic [`DISPATCH_DATA_W-1:0] data_t;

  // processor number plus active / non-active flag bits
  // also wide enough for the processor counts
  typedef logic [`DISPATCH_CPU_INDEX_W-1:0] cpu_index_t;

endpackage

// ==== hdl/dispatch_ctl_pkg.sv ====
package dispatch_ctl_pkg;

  // messages a processor puts on cpu_msg
  typedef enum logic [7:0] {
    // idle bus
    CPU_MSG_NONE  = 8'h00,
    // processor came out of its reset sequence
    CPU_MSG_RESET = 8'h01,
    // processor picked up work and is now active
    CPU_MSG_START = 8'h02,
    // processor finished and goes back to the idle pool
    CPU_MSG_END   = 8'h03,
    // turn given back without a memory access
    CPU_MSG_YIELD = 8'h04
  } cpu_msg_t;

  // scheduler FSM
  typedef enum logic [1:0] {
    // processors held in reset, counting reset reports
    SCHED_RESET_WAIT,
    // pick the next processor and pulse cpu_q
    SCHED_GRANT,
    // granted processor owns the bus
    SCHED_TURN,
    // memory request being passed to the queue
    SCHED_HANDOFF
  } sched_state_t;

endpackage

// ==== hdl/cpu_scheduler.sv ====
`include "dispatch_defines.svh"

module cpu_scheduler (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cpu_e,
  input  logic                           read_q,
  input  logic                           write_q,
  input  dispatch_ctl_pkg::cpu_msg_t     cpu_msg,
  input  logic                           ext_rst_e,
  input  dispatch_types_pkg::addr_t      addr_in,
  input  dispatch_types_pkg::data_t      data_in,
  input  logic                           ack_a,
  output dispatch_types_pkg::cpu_index_t cpu_index,
  output logic                           cpu_q,
  output logic                           ext_rst_b,
  output logic                           req_a,
  output logic                           req_we,
  output dispatch_types_pkg::addr_t      req_addr,
  output dispatch_types_pkg::data_t      req_data,
  output dispatch_types_pkg::cpu_index_t req_cpu
);
  import dispatch_types_pkg::*;
  import dispatch_ctl_pkg::*;

  sched_state_t state;

  // processors that have started
  cpu_index_t act_cnt;
  // processors still waiting for a start
  cpu_index_t nact_cnt;
  // last active processor served
  cpu_index_t rr_ptr;
  // previous grant went to the non-active slot
  logic       last_nact;

  logic       grant_nact;
  cpu_index_t rr_next;
  logic       take_req;

  // non-active slot gets every other turn while someone is left to start
  // when nobody runs yet it gets every turn
  assign grant_nact = (nact_cnt != '0) && ((act_cnt == '0) || !last_nact);

  // step the pointer and wrap inside the current active count
  assign rr_next = (rr_ptr >= act_cnt - cpu_index_t'(1)) ? '0 : rr_ptr + cpu_index_t'(1);

  // memory access from the processor holding the turn
  assign take_req = (state == SCHED_TURN) && (read_q || write_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SCHED_RESET_WAIT;
      cpu_index <= '0;
      cpu_q     <= 1'b0;
      ext_rst_b <= 1'b1;
      req_a     <= 1'b0;
      act_cnt   <= '0;
      nact_cnt  <= cpu_index_t'(`DISPATCH_CPU_QUANTITY);
      rr_ptr    <= '0;
      last_nact <= 1'b0;
    end else begin
      case (state)
        SCHED_RESET_WAIT: begin
          if (ext_rst_e) begin
            // release the processors, index bus back to zero
            ext_rst_b <= 1'b0;
            cpu_index <= '0;
            state     <= SCHED_GRANT;
          end else if (cpu_msg == CPU_MSG_RESET) begin
            // one more processor reported reset done
            cpu_index <= cpu_index + cpu_index_t'(1);
          end
        end

        SCHED_GRANT: begin
          cpu_q <= 1'b1;
          if (grant_nact) begin
            cpu_index <= `DISPATCH_CPU_NONACTIVE;
            last_nact <= 1'b1;
          end else begin
            rr_ptr    <= rr_next;
            cpu_index <= rr_next | `DISPATCH_CPU_ACTIVE;
            last_nact <= 1'b0;
          end
          state <= SCHED_TURN;
        end

        SCHED_TURN: begin
          // single cycle grant pulse
          cpu_q <= 1'b0;
          if (read_q || write_q) begin
            req_a <= 1'b1;
            state <= SCHED_HANDOFF;
          end else if (cpu_e) begin
            case (cpu_msg)
              CPU_MSG_START: begin
                if (nact_cnt != '0) begin
                  nact_cnt <= nact_cnt - cpu_index_t'(1);
                  act_cnt  <= act_cnt + cpu_index_t'(1);
                end
              end
              CPU_MSG_END: begin
                if (act_cnt != '0) begin
                  act_cnt  <= act_cnt - cpu_index_t'(1);
                  nact_cnt <= nact_cnt + cpu_index_t'(1);
                end
              end
              // yield and anything else just end the turn
              default: begin
              end
            endcase
            state <= SCHED_GRANT;
          end
        end

        SCHED_HANDOFF: begin
          if (req_a && ack_a) begin
            // entry stored in the queue
            req_a <= 1'b0;
          end else if (!req_a && !ack_a) begin
            // handshake back to idle, turn is over
            state <= SCHED_GRANT;
          end
        end

        default: state <= SCHED_RESET_WAIT;
      endcase
    end
  end

  // request payload, held while req_a is up
  always_ff @(posedge clk) begin
    if (take_req) begin
      // read wins if both strobes show up
      req_we   <= ~read_q;
      req_addr <= addr_in;
      req_data <= data_in;
      req_cpu  <= cpu_index;
    end
  end

endmodule

// ==== hdl/mem_request_queue.sv ====
module mem_request_queue (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_a,
  input  logic                           req_we,
  input  dispatch_types_pkg::addr_t      req_addr,
  input  dispatch_types_pkg::data_t      req_data,
  input  dispatch_types_pkg::cpu_index_t req_cpu,
  input  logic                           ack_b,
  output logic                           ack_a,
  output logic                           req_b,
  output logic                           mem_we,
  output dispatch_types_pkg::addr_t      mem_addr,
  output dispatch_types_pkg::data_t      mem_data,
  output dispatch_types_pkg::cpu_index_t mem_cpu
);
  import dispatch_types_pkg::*;

  // two request slots
  logic       ent_we   [2];
  addr_t      ent_addr [2];
  data_t      ent_data [2];
  cpu_index_t ent_cpu  [2];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  logic       push;
  logic       pop;

  // new request, not yet acked, and room left
  assign push = req_a && !ack_a && (count != 2'd2);
  // memory port took the head entry
  assign pop  = req_b && ack_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_a  <= 1'b0;
      req_b  <= 1'b0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      // responder side toward the scheduler
      if (push) begin
        ack_a  <= 1'b1;
        wr_ptr <= ~wr_ptr;
      end else if (!req_a) begin
        ack_a <= 1'b0;
      end

      // requester side toward the memory port
      if (pop) begin
        req_b  <= 1'b0;
        rd_ptr <= ~rd_ptr;
      end else if (!req_b && !ack_b && (count != 2'd0)) begin
        req_b <= 1'b1;
      end

      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ent_we[wr_ptr]   <= req_we;
      ent_addr[wr_ptr] <= req_addr;
      ent_data[wr_ptr] <= req_data;
      ent_cpu[wr_ptr]  <= req_cpu;
    end
  end

  // oldest entry, stable until the pop
  assign mem_we   = ent_we[rd_ptr];
  assign mem_addr = ent_addr[rd_ptr];
  assign mem_data = ent_data[rd_ptr];
  assign mem_cpu  = ent_cpu[rd_ptr];

endmodule

// ==== hdl/ext_mem_port.sv ====
module ext_mem_port (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_b,
  input  logic                           mem_we,
  input  dispatch_types_pkg::addr_t      mem_addr,
  input  dispatch_types_pkg::data_t      mem_data,
  input  dispatch_types_pkg::cpu_index_t mem_cpu,
  input  logic                           ext_read_dn,
  input  logic                           ext_write_dn,
  input  dispatch_types_pkg::data_t      ext_mem_data_in,
  output logic                           ack_b,
  output logic                           ext_read_q,
  output logic                           ext_write_q,
  output dispatch_types_pkg::addr_t      ext_mem_addr_out,
  output dispatch_types_pkg::data_t      ext_mem_data_out,
  output logic                           read_dn,
  output logic                           write_dn,
  output dispatch_types_pkg::addr_t      addr_out,
  output dispatch_types_pkg::data_t      data_out,
  output dispatch_types_pkg::cpu_index_t reply_cpu
);
  import dispatch_types_pkg::*;

  // access in flight
  addr_t      cur_addr;
  data_t      cur_data;
  cpu_index_t cur_cpu;

  logic       take;
  logic       rd_done;
  logic       wr_done;

  // accept only with link b idle and no access running
  assign take    = req_b && !ack_b && !ext_read_q && !ext_write_q;
  assign rd_done = ext_read_q && ext_read_dn;
  assign wr_done = ext_write_q && ext_write_dn;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_b       <= 1'b0;
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
      read_dn     <= 1'b0;
      write_dn    <= 1'b0;
    end else begin
      // reply strobes last one cycle
      read_dn  <= rd_done;
      write_dn <= wr_done;

      if (take) begin
        ack_b       <= 1'b1;
        ext_read_q  <= ~mem_we;
        ext_write_q <= mem_we;
      end else if (!req_b) begin
        ack_b <= 1'b0;
      end

      // level request held until the done pulse
      if (rd_done) begin
        ext_read_q <= 1'b0;
      end
      if (wr_done) begin
        ext_write_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cur_addr <= mem_addr;
      cur_data <= mem_data;
      cur_cpu  <= mem_cpu;
    end
    // tagged reply back to the processors
    if (rd_done || wr_done) begin
      addr_out  <= cur_addr;
      // read returns memory data, write echoes what was stored
      data_out  <= rd_done ? ext_mem_data_in : cur_data;
      reply_cpu <= cur_cpu;
    end
  end

  assign ext_mem_addr_out = cur_addr;
  assign ext_mem_data_out = cur_data;

endmodule

// ==== hdl/cpu_dispatcher.sv ====
module cpu_dispatcher (
  input  logic                           clk,
  input  logic                           rst,
  // processor side
  output dispatch_types_pkg::cpu_index_t cpu_index,
  output logic                           cpu_q,
  input  logic                           cpu_e,
  input  dispatch_ctl_pkg::cpu_msg_t     cpu_msg,
  input  logic                           read_q,
  input  logic                           write_q,
  input  dispatch_types_pkg::addr_t      addr_in,
  input  dispatch_types_pkg::data_t      data_in,
  output logic                           read_dn,
  output logic                           write_dn,
  output dispatch_types_pkg::addr_t      addr_out,
  output dispatch_types_pkg::data_t      data_out,
  output dispatch_types_pkg::cpu_index_t reply_cpu,
  output logic                           ext_rst_b,
  input  logic                           ext_rst_e,
  // external memory side
  output logic                           ext_read_q,
  output logic                           ext_write_q,
  output dispatch_types_pkg::addr_t      ext_mem_addr_out,
  output dispatch_types_pkg::data_t      ext_mem_data_out,
  input  logic                           ext_read_dn,
  input  logic                           ext_write_dn,
  input  dispatch_types_pkg::data_t      ext_mem_data_in
);
  import dispatch_types_pkg::*;

  // scheduler to queue
  logic       req_a;
  logic       ack_a;
  logic       req_we;
  addr_t      req_addr;
  data_t      req_data;
  cpu_index_t req_cpu;

  // queue to memory port
  logic       req_b;
  logic       ack_b;
  logic       mem_we;
  addr_t      mem_addr;
  data_t      mem_data;
  cpu_index_t mem_cpu;

  cpu_scheduler u_sched (
    .clk       (clk),
    .rst       (rst),
    .cpu_e     (cpu_e),
    .read_q    (read_q),
    .write_q   (write_q),
    .cpu_msg   (cpu_msg),
    .ext_rst_e (ext_rst_e),
    .addr_in   (addr_in),
    .data_in   (data_in),
    .ack_a     (ack_a),
    .cpu_index (cpu_index),
    .cpu_q     (cpu_q),
    .ext_rst_b (ext_rst_b),
    .req_a     (req_a),
    .req_we    (req_we),
    .req_addr  (req_addr),
    .req_data  (req_data),
    .req_cpu   (req_cpu)
  );

  mem_request_queue u_queue (
    .clk      (clk),
    .rst      (rst),
    .req_a    (req_a),
    .req_we   (req_we),
    .req_addr (req_addr),
    .req_data (req_data),
    .req_cpu  (req_cpu),
    .ack_b    (ack_b),
    .ack_a    (ack_a),
    .req_b    (req_b),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .mem_cpu  (mem_cpu)
  );

  ext_mem_port u_mem_port (
    .clk              (clk),
    .rst              (rst),
    .req_b            (req_b),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_data         (mem_data),
    .mem_cpu          (mem_cpu),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_mem_data_in  (ext_mem_data_in),
    .ack_b            (ack_b),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .addr_out         (addr_out),
    .data_out         (data_out),
    .reply_cpu        (reply_cpu)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst
);
  // 40 unit period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset over the first 4 rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== dv/tb_cpu_dispatcher.sv ====
`include "dispatch_defines.svh"

module tb_cpu_dispatcher;
  import dispatch_types_pkg::*;
  import dispatch_ctl_pkg::*;

  localparam int    TIMEOUT = 300;
  localparam addr_t BASE    = 32'h0000_1000;

  logic       clk;
  logic       rst;
  cpu_index_t cpu_index;
  logic       cpu_q;
  logic       cpu_e     = 1'b0;
  cpu_msg_t   cpu_msg   = CPU_MSG_NONE;
  logic       read_q    = 1'b0;
  logic       write_q   = 1'b0;
  addr_t      addr_in   = '0;
  data_t      data_in   = '0;
  logic       ext_rst_e = 1'b0;
  logic       read_dn;
  logic       write_dn;
  addr_t      addr_out;
  data_t      data_out;
  cpu_index_t reply_cpu;
  logic       ext_rst_b;
  logic       ext_read_q;
  logic       ext_write_q;
  addr_t      ext_mem_addr_out;
  data_t      ext_mem_data_out;
  logic       ext_read_dn     = 1'b0;
  logic       ext_write_dn    = 1'b0;
  data_t      ext_mem_data_in = '0;

  integer seed;
  int     err_cnt   = 0;
  int     tmo_cnt   = 0;
  bit     timed_out = 1'b0;

  // scheduler model kept from the messages sent
  int         act_cnt;
  int         nact_cnt;
  int         rr_ptr;
  bit         last_nact;
  cpu_index_t grant;

  // memory seen by the DUT and the in-order reference image
  data_t ext_mem [16];
  data_t ref_mem [16];
  int    delay_tab [64];
  int    mem_ops    = 0;
  int    mem_wait   = 0;
  bit    mem_busy   = 1'b0;
  int    slow_extra = 0;

  // back-pressure stimulus
  bit    bp_we   [12];
  int    bp_idx  [12];
  data_t bp_data [12];

  // outstanding requests in issue order
  bit         sb_we   [$];
  addr_t      sb_addr [$];
  data_t      sb_data [$];
  cpu_index_t sb_cpu  [$];

  tb_clock_gen clk_gen (
    .clk (clk),
    .rst (rst)
  );

  cpu_dispatcher UUT (
    .clk              (clk),
    .rst              (rst),
    .cpu_index        (cpu_index),
    .cpu_q            (cpu_q),
    .cpu_e            (cpu_e),
    .cpu_msg          (cpu_msg),
    .read_q           (read_q),
    .write_q          (write_q),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .addr_out         (addr_out),
    .data_out         (data_out),
    .reply_cpu        (reply_cpu),
    .ext_rst_b        (ext_rst_b),
    .ext_rst_e        (ext_rst_e),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_mem_data_in  (ext_mem_data_in)
  );

  // grant strobe is a single cycle
  cpu_q_pulse: assert property (@(posedge clk) disable iff (rst) cpu_q |=> !cpu_q)
    else begin
      err_cnt++;
      $display("cpu_q stayed high for more than one cycle");
    end

  // level requests held until the done pulse
  read_hold: assert property (@(posedge clk) disable iff (rst)
    ext_read_q && !ext_read_dn |=> ext_read_q)
    else begin
      err_cnt++;
      $display("ext_read_q dropped before ext_read_dn");
    end

  write_hold: assert property (@(posedge clk) disable iff (rst)
    ext_write_q && !ext_write_dn |=> ext_write_q)
    else begin
      err_cnt++;
      $display("ext_write_q dropped before ext_write_dn");
    end

  // reply one cycle after the memory done pulse
  read_reply: assert property (@(posedge clk) disable iff (rst)
    ext_read_q && ext_read_dn |=> read_dn && !ext_read_q)
    else begin
      err_cnt++;
      $display("no read_dn one cycle after ext_read_dn");
    end

  write_reply: assert property (@(posedge clk) disable iff (rst)
    ext_write_q && ext_write_dn |=> write_dn && !ext_write_q)
    else begin
      err_cnt++;
      $display("no write_dn one cycle after ext_write_dn");
    end

  one_access: assert property (@(posedge clk) disable iff (rst)
    !(ext_read_q && ext_write_q) && !(read_dn && write_dn))
    else begin
      err_cnt++;
      $display("read and write active in the same cycle");
    end

  function automatic data_t fill_word(addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h6c3e_9a51;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERROR: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic timeout_hit(string what);
    tmo_cnt++;
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  // wait for the cpu_q pulse and check the round-robin grant
  task automatic next_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (!cpu_q && n < TIMEOUT && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_q && !timed_out) timeout_hit("a grant on cpu_q");
    if (nact_cnt > 0 && (act_cnt == 0 || !last_nact)) begin
      grant     = `DISPATCH_CPU_NONACTIVE;
      last_nact = 1'b1;
    end else begin
      rr_ptr    = (rr_ptr + 1 >= act_cnt) ? 0 : rr_ptr + 1;
      grant     = cpu_index_t'(rr_ptr) | `DISPATCH_CPU_ACTIVE;
      last_nact = 1'b0;
    end
    if (!timed_out) check_value("cpu_index", cpu_index, grant);
  endtask

  // finish the turn with a message
  task automatic end_turn(cpu_msg_t msg);
    cpu_e   = 1'b1;
    cpu_msg = msg;
    if (msg == CPU_MSG_START && nact_cnt > 0) begin
      nact_cnt--;
      act_cnt++;
    end else if (msg == CPU_MSG_END && act_cnt > 0) begin
      act_cnt--;
      nact_cnt++;
    end
    @(negedge clk);
    cpu_e   = 1'b0;
    cpu_msg = CPU_MSG_NONE;
  endtask

  // memory access ends the turn
  // expected reply goes on the scoreboard
  task automatic issue_access(bit we, int idx, data_t wdata);
    addr_t a;
    a       = BASE + addr_t'(idx * 4);
    addr_in = a;
    data_in = wdata;
    read_q  = !we;
    write_q = we;
    sb_we.push_back(we);
    sb_addr.push_back(a);
    sb_data.push_back(we ? wdata : ref_mem[idx]);
    sb_cpu.push_back(grant);
    if (we) ref_mem[idx] = wdata;
    @(negedge clk);
    read_q  = 1'b0;
    write_q = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((sb_we.size() != 0 || mem_busy) && n < TIMEOUT && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if ((sb_we.size() != 0 || mem_busy) && !timed_out) begin
      timeout_hit("outstanding memory replies");
    end
  endtask

  // external memory and reply checker
  always @(negedge clk) begin : mem_model
    int idx;
    idx          = ext_mem_addr_out[5:2];
    ext_read_dn  = 1'b0;
    ext_write_dn = 1'b0;
    if (rst) begin
      mem_busy = 1'b0;
    end else begin
      if (read_dn || write_dn) begin
        if (sb_we.size() == 0) begin
          err_cnt++;
          $display("reply arrived with no request outstanding");
        end else begin
          check_value("write_dn", write_dn, sb_we[0]);
          check_value("addr_out", addr_out, sb_addr[0]);
          check_value("data_out", data_out, sb_data[0]);
          check_value("reply_cpu", reply_cpu, sb_cpu[0]);
          void'(sb_we.pop_front());
          void'(sb_addr.pop_front());
          void'(sb_data.pop_front());
          void'(sb_cpu.pop_front());
        end
      end
      // new access must be the oldest outstanding request
      if (!mem_busy && (ext_read_q || ext_write_q)) begin
        if (sb_we.size() != 0) begin
          check_value("ext_write_q", ext_write_q, sb_we[0]);
          check_value("ext_mem_addr_out", ext_mem_addr_out, sb_addr[0]);
          if (sb_we[0]) check_value("ext_mem_data_out", ext_mem_data_out, sb_data[0]);
        end
        mem_busy = 1'b1;
        mem_wait = delay_tab[mem_ops % 64] + slow_extra;
        mem_ops++;
      end
      if (mem_busy) begin
        if (mem_wait == 0) begin
          if (ext_write_q) begin
            ext_mem[idx] = ext_mem_data_out;
            ext_write_dn = 1'b1;
          end else begin
            ext_mem_data_in = ext_mem[idx];
            ext_read_dn     = 1'b1;
          end
          mem_busy = 1'b0;
        end else begin
          mem_wait--;
        end
      end
    end
  end

  initial begin : stimulus
    int n;
    seed      = 32'ha8d5_54a6;
    act_cnt   = 0;
    nact_cnt  = `DISPATCH_CPU_QUANTITY;
    rr_ptr    = 0;
    last_nact = 1'b0;
    grant     = '0;
    for (int i = 0; i < 16; i++) begin
      ext_mem[i] = fill_word(BASE + addr_t'(i * 4));
      ref_mem[i] = fill_word(BASE + addr_t'(i * 4));
    end
    // memory latency 0 to 5 cycles
    for (int i = 0; i < 64; i++) delay_tab[i] = {$random(seed)} % 6;
    for (int i = 0; i < 12; i++) begin
      bp_we[i]   = ($random(seed) & 1) != 0;
      bp_idx[i]  = {$random(seed)} % 16;
      bp_data[i] = $random(seed);
    end

    n = 0;
    @(negedge clk);
    while (rst && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst) timeout_hit("reset release");

    // idle values out of reset
    check_value("cpu_q", cpu_q, 1'b0);
    check_value("ext_read_q", ext_read_q, 1'b0);
    check_value("ext_write_q", ext_write_q, 1'b0);
    check_value("read_dn", read_dn, 1'b0);
    check_value("write_dn", write_dn, 1'b0);
    check_value("ext_rst_b", ext_rst_b, 1'b1);
    check_value("cpu_index", cpu_index, 0);

    // reset reports count up on cpu_index
    for (int k = 1; k <= `DISPATCH_CPU_QUANTITY; k++) begin
      cpu_msg = CPU_MSG_RESET;
      @(negedge clk);
      check_value("cpu_index", cpu_index, k);
    end
    cpu_msg   = CPU_MSG_NONE;
    ext_rst_e = 1'b1;
    @(negedge clk);
    ext_rst_e = 1'b0;
    check_value("ext_rst_b", ext_rst_b, 1'b0);
    check_value("cpu_index", cpu_index, 0);

    // nobody started so only the non-active slot
    repeat (2) begin
      next_grant();
      end_turn(CPU_MSG_YIELD);
    end
    // three starts then alternating slots
    repeat (3) begin
      next_grant();
      end_turn(CPU_MSG_START);
    end
    repeat (8) begin
      next_grant();
      end_turn(CPU_MSG_YIELD);
    end

    // read untouched word, overwrite, read back
    next_grant();
    issue_access(1'b0, 3, '0);
    next_grant();
    issue_access(1'b1, 3, 32'hc0de_5a11);
    next_grant();
    issue_access(1'b0, 3, '0);
    next_grant();
    wait_drain();
    slow_extra = 8;
    end_turn(CPU_MSG_YIELD);

    // one processor finishes and the pointer wraps in two
    next_grant();
    end_turn(CPU_MSG_END);
    repeat (6) begin
      next_grant();
      end_turn(CPU_MSG_YIELD);
    end

    // slow memory with a request on every turn fills the queue
    for (int i = 0; i < 12; i++) begin
      next_grant();
      issue_access(bp_we[i], bp_idx[i], bp_data[i]);
    end
    next_grant();
    wait_drain();
    end_turn(CPU_MSG_YIELD);

    $display("check failures: %0d, timeouts: %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== cpu_dispatcher.f ====
+incdir+hdl
hdl/dispatch_types_pkg.sv
hdl/dispatch_ctl_pkg.sv
hdl/cpu_scheduler.sv
hdl/mem_request_queue.sv
hdl/ext_mem_port.sv
hdl/cpu_dispatcher.sv
dv/tb_clock_gen.sv
dv/tb_cpu_dispatcher.sv
